// File: tb.f
+incdir+.
video_std_pkg.sv
sdi_word_pkg.sv
sdi_timing_gen.sv
sdi_payload_id_insert.sv
sdi_ln_crc_insert.sv
sdi_video_source.sv
sdi_video_source_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile the sdi source testbench with verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f tb.f \
  --top-module sdi_video_source_tb -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q -F -x '*** PASSED ***' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: sdi_video_source_tb.sv
// testbench for the sdi test-pattern source
// reference raster model for trs, ln, crc-18, 352m packet and bars
// directed tests for lock, trs, ln/crc, payload id, anc off and bars
`timescale 1ns/1ns
`include "sdi_settings.svh"

module sdi_video_source_tb;

  import video_std_pkg::*;

  localparam int hb = `SDI_HBLANK_WORDS;
  localparam int wpl = `SDI_ACTIVE_WORDS + `SDI_HBLANK_WORDS;
  localparam int n_lines = `SDI_TOTAL_LINES;
  localparam int frame_words = wpl * n_lines;

  // word regions for scan_frame
  localparam int chk_trs = 1;
  localparam int chk_lncrc = 2;
  localparam int chk_hblank = 4;
  localparam int chk_active = 8;

  // 75% bar luma and cb levels from white to black
  localparam logic [9:0] ref_y [8] = '{
    10'h2d1, 10'h286, 10'h20d, 10'h1c2, 10'h14f, 10'h104, 10'h08b, 10'h040
  };
  localparam logic [9:0] ref_c [8] = '{
    10'h200, 10'h0b0, 10'h25e, 10'h10e, 10'h2f2, 10'h1a2, 10'h350, 10'h200
  };

  logic        vid_clk;
  logic        arst_n;
  video_std_t  vid_std;
  logic        enable_anc;
  logic        vid_datavalid;
  logic [19:0] vid_data;
  logic        vid_locked;

  // position and value of the word sampled last
  int          cur_line;
  int          cur_word;
  logic [19:0] cur_data;
  logic [19:0] exp_data;
  // model state
  video_std_t  frm_std;
  logic        frm_anc;
  logic [17:0] crc_y;
  logic [17:0] crc_c;
  logic        locked_seen;
  logic        timed_out;
  int          checks;
  int          errors;
  int          errs_at_start;

  sdi_video_source dut_i (
    .vid_clk       (vid_clk),
    .arst_n        (arst_n),
    .vid_std       (vid_std),
    .enable_anc    (enable_anc),
    .vid_datavalid (vid_datavalid),
    .vid_data      (vid_data),
    .vid_locked    (vid_locked)
  );

  always #50 vid_clk = ~vid_clk;

  // ------------------------------
  // reference model
  // ------------------------------

  // b8 even parity and b9 its inverse
  function automatic logic [9:0] anc10(input logic [7:0] b);
    logic p;
    p = 1'b0;
    for (int i = 0; i < 8; i++) begin
      p = p ^ b[i];
    end
    return {~p, p, b};
  endfunction

  // 352m bytes with the first byte on top
  function automatic logic [31:0] pid_ref(input video_std_t s);
    case (s)
      std_sd:  return 32'h8106_0000;
      std_hd:  return 32'h8506_8000;
      std_3ga: return 32'h89cb_8000;
      default: return 32'h8a06_8100;
    endcase
  endfunction

  // lsb first with feedback into the x^18, x^5 and x^4 taps
  function automatic logic [17:0] crc_word(input logic [17:0] c, input logic [9:0] d);
    logic [17:0] r;
    logic        fb;
    r = c;
    for (int i = 0; i < 10; i++) begin
      fb = r[0] ^ d[i];
      r  = {fb, r[17:15], r[14] ^ fb, r[13] ^ fb, r[12:1]};
    end
    return r;
  endfunction

  // packet word k of adf x3, did, sdid, dc, udw x4 and checksum
  function automatic logic [9:0] pkt_ref(input int k);
    logic [7:0]  v [7];
    logic [31:0] b;
    logic [9:0]  w;
    logic [8:0]  sum;
    b = pid_ref(frm_std);
    v[0] = 8'h41;
    v[1] = 8'h01;
    v[2] = 8'h04;
    v[3] = b[31:24];
    v[4] = b[23:16];
    v[5] = b[15:8];
    v[6] = b[7:0];
    sum = '0;
    for (int i = 0; i < 7; i++) begin
      w   = anc10(v[i]);
      sum = sum + w[8:0];
    end
    if (k == 0) begin
      return 10'h000;
    end else if (k < 3) begin
      return 10'h3ff;
    end else if (k < 10) begin
      return anc10(v[k - 3]);
    end
    return {~sum[8], sum};
  endfunction

  // expected {y, c} at line ln, word w
  function automatic logic [19:0] expected_word(input int ln, input int w);
    logic        v;
    logic        h;
    logic [9:0]  xyz;
    logic [9:0]  y;
    logic [9:0]  c;
    logic [10:0] l;
    int          bar;
    l = 11'(ln);
    v = !(ln >= `SDI_FIRST_ACTIVE && ln <= `SDI_LAST_ACTIVE);
    h = (w < 4);
    // f = 0 so p3 = v^h, p2 = h, p1 = v, p0 = v^h
    xyz = {1'b1, 1'b0, v, h, v ^ h, h, v, v ^ h, 2'b00};
    y = 10'h040;
    c = 10'h200;
    if (w >= hb) begin
      if (!v) begin
        bar = (w - hb) / (`SDI_ACTIVE_WORDS / 8);
        y = ref_y[bar];
        c = ref_c[bar];
      end
    end else if (w == 0 || w == hb - 4) begin
      y = 10'h3ff;
      c = 10'h3ff;
    end else if (w < 3 || (w > hb - 4 && w < hb - 1)) begin
      y = 10'h000;
      c = 10'h000;
    end else if (w == 3 || w == hb - 1) begin
      y = xyz;
      c = xyz;
    end else if (w == 4) begin
      y = {~l[6], l[6:0], 2'b00};
      c = y;
    end else if (w == 5) begin
      y = {1'b1, 3'b000, l[10:7], 2'b00};
      c = y;
    end else if (w == 6) begin
      y = {~crc_y[8], crc_y[8:0]};
      c = {~crc_c[8], crc_c[8:0]};
    end else if (w == 7) begin
      y = {~crc_y[17], crc_y[17:9]};
      c = {~crc_c[17], crc_c[17:9]};
    end else if (ln == `SDI_PID_LINE && frm_anc && w < 8 + 11) begin
      y = pkt_ref(w - 8);
    end
    return {y, c};
  endfunction

  // ------------------------------
  // sampling and checks
  // ------------------------------

  task automatic compare(input logic [19:0] got, input logic [19:0] exp, input string what);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("FAIL %0t ns: %s, got %05h expected %05h", $time, what, got, exp);
    end
  endtask

  // take the output word, build the expected one, run the model crc
  task automatic sample_word();
    cur_data = vid_data;
    // standard and anc enable were latched at the frame start
    if (cur_line == 1 && cur_word == 0) begin
      frm_std = vid_std;
      frm_anc = enable_anc;
    end
    exp_data = expected_word(cur_line, cur_word);
    if (cur_word == hb) begin
      crc_y = crc_word(18'd0, exp_data[19:10]);
      crc_c = crc_word(18'd0, exp_data[9:0]);
    end else if (cur_word > hb || cur_word < 6) begin
      crc_y = crc_word(crc_y, exp_data[19:10]);
      crc_c = crc_word(crc_c, exp_data[9:0]);
    end
  endtask

  // one word forward on the falling edge
  task automatic advance();
    @(negedge vid_clk);
    if (cur_word == wpl - 1) begin
      cur_word = 0;
      cur_line = (cur_line == n_lines) ? 1 : cur_line + 1;
    end else begin
      cur_word = cur_word + 1;
    end
    sample_word();
    compare(20'(vid_datavalid), 20'd1, "vid_datavalid dropped");
    if (locked_seen) begin
      compare(20'(vid_locked), 20'd1, "vid_locked dropped");
    end
  endtask

  task automatic sync_frame();
    int n;
    n = 0;
    while (!(cur_line == 1 && cur_word == 0) && n < 2 * frame_words) begin
      advance();
      n = n + 1;
    end
    if (!(cur_line == 1 && cur_word == 0)) begin
      $display("timeout: start of frame was not reached");
      timed_out = 1'b1;
    end
  endtask

  // inputs changed just after the frame start apply from the next frame
  task automatic apply_at_frame_start(input video_std_t s, input logic en);
    sync_frame();
    vid_std    = s;
    enable_anc = en;
  endtask

  function automatic int region_of(input int w);
    if (w < 4 || (w >= hb - 4 && w < hb)) begin
      return chk_trs;
    end else if (w < 8) begin
      return chk_lncrc;
    end else if (w < hb) begin
      return chk_hblank;
    end
    return chk_active;
  endfunction

  // compare the selected regions over one whole frame
  task automatic scan_frame(input int mask, input string label);
    int n;
    sync_frame();
    for (n = 0; n < frame_words && !timed_out; n++) begin
      if ((region_of(cur_word) & mask) != 0) begin
        compare(cur_data, exp_data,
                $sformatf("%s line %0d word %0d", label, cur_line, cur_word));
      end
      if (n < frame_words - 1) begin
        advance();
      end
    end
  endtask

  task automatic report(input string name);
    if (errors == errs_at_start && !timed_out) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d mismatches", name, errors - errs_at_start);
    end
    errs_at_start = errors;
  endtask

  // ------------------------------
  // tests
  // ------------------------------

  task automatic reset_and_lock();
    int n;
    repeat (3) begin
      @(negedge vid_clk);
      compare(20'(vid_datavalid), 20'd0, "vid_datavalid high in reset");
      compare(20'(vid_locked), 20'd0, "vid_locked high in reset");
    end
    arst_n = 1'b1;
    n = 0;
    while (vid_datavalid !== 1'b1 && n < 20) begin
      compare(20'(vid_locked), 20'd0, "vid_locked before first word");
      @(negedge vid_clk);
      n = n + 1;
    end
    if (vid_datavalid !== 1'b1) begin
      $display("timeout: vid_datavalid did not go high after reset");
      timed_out = 1'b1;
      return;
    end
    // first word out is eav of line 1
    cur_line = 1;
    cur_word = 0;
    sample_word();
    compare(cur_data, exp_data, "first word");
    n = 0;
    while (cur_word != hb - 4 && n < wpl) begin
      compare(20'(vid_locked), 20'd0, "vid_locked before sav of line 1");
      advance();
      n = n + 1;
    end
    compare(20'(vid_locked), 20'd1, "vid_locked at sav of line 1");
    locked_seen = 1'b1;
  endtask

  task automatic trs_words();
    scan_frame(chk_trs, "trs");
  endtask

  task automatic ln_crc_words();
    scan_frame(chk_lncrc, "ln/crc");
  endtask

  // all four standards in a shuffled order
  task automatic payload_id_per_std();
    video_std_t order [4];
    video_std_t t;
    int         j;
    order[0] = std_sd;
    order[1] = std_hd;
    order[2] = std_3ga;
    order[3] = std_3gb;
    for (int i = 3; i > 0; i--) begin
      j = int'($urandom % (i + 1));
      t = order[i];
      order[i] = order[j];
      order[j] = t;
    end
    // each frame carries the standard applied at the previous frame start
    for (int i = 0; i < 5 && !timed_out; i++) begin
      if (i < 4) begin
        apply_at_frame_start(order[i], 1'b1);
      end else begin
        sync_frame();
      end
      scan_frame(chk_hblank, $sformatf("pid %s", frm_std.name()));
    end
  endtask

  task automatic anc_disable();
    apply_at_frame_start(vid_std, 1'b0);
    // packet stays in the frame where enable_anc drops
    scan_frame(chk_hblank | chk_lncrc, "anc off, frame of the change");
    scan_frame(chk_hblank | chk_lncrc, "anc off");
  endtask

  task automatic color_bars();
    scan_frame(chk_active, "bars");
  endtask

  initial begin
    vid_clk       = 1'b0;
    arst_n        = 1'b0;
    vid_std       = std_hd;
    enable_anc    = 1'b1;
    cur_line      = 1;
    cur_word      = 0;
    cur_data      = '0;
    exp_data      = '0;
    frm_std       = std_hd;
    frm_anc       = 1'b1;
    crc_y         = '0;
    crc_c         = '0;
    locked_seen   = 1'b0;
    timed_out     = 1'b0;
    checks        = 0;
    errors        = 0;
    errs_at_start = 0;
    void'($urandom(32'hc0bd));

    reset_and_lock();
    report("reset_lock");
    if (!timed_out) begin
      trs_words();
      report("trs");
      ln_crc_words();
      report("ln_crc");
      payload_id_per_std();
      report("payload_id");
      anc_disable();
      report("anc_off");
      color_bars();
      report("bars");
    end

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: sdi_video_source.sv
// sdi test-pattern source top level
// timing gen -> payload-id insert -> ln/crc insert
// sticky locked flag
`timescale 1ns/1ns

module sdi_video_source (
  input  logic                      vid_clk,
  input  logic                      arst_n,
  input  video_std_pkg::video_std_t vid_std,
  input  logic                      enable_anc,
  output logic                      vid_datavalid,
  output logic [19:0]               vid_data,
  output logic                      vid_locked
);

  import video_std_pkg::*;
  import sdi_word_pkg::*;

  // timing gen outputs
  logic        gen_valid;
  logic [19:0] gen_data;
  word_slot_t  gen_slot;
  logic [10:0] gen_line;
  video_std_t  frame_std;
  logic        frame_anc_en;

  // payload-id stage outputs
  logic        pid_valid;
  logic [19:0] pid_data;
  word_slot_t  pid_slot;
  logic [10:0] pid_line;

  logic        frame_start;
  logic        locked_q;

  // ------------------------------
  // pipeline
  // ------------------------------

  sdi_timing_gen gen_i (
    .vid_clk      (vid_clk),
    .arst_n       (arst_n),
    .vid_std      (vid_std),
    .enable_anc   (enable_anc),
    .out_valid    (gen_valid),
    .out_data     (gen_data),
    .out_slot     (gen_slot),
    .out_line     (gen_line),
    .frame_std    (frame_std),
    .frame_anc_en (frame_anc_en)
  );

  sdi_payload_id_insert pid_i (
    .vid_clk      (vid_clk),
    .arst_n       (arst_n),
    .frame_std    (frame_std),
    .frame_anc_en (frame_anc_en),
    .in_valid     (gen_valid),
    .in_data      (gen_data),
    .in_slot      (gen_slot),
    .in_line      (gen_line),
    .out_valid    (pid_valid),
    .out_data     (pid_data),
    .out_slot     (pid_slot),
    .out_line     (pid_line)
  );

  // last stage tags are not needed past the top
  sdi_ln_crc_insert lncrc_i (
    .vid_clk     (vid_clk),
    .arst_n      (arst_n),
    .in_valid    (pid_valid),
    .in_data     (pid_data),
    .in_slot     (pid_slot),
    .in_line     (pid_line),
    .out_valid   (vid_datavalid),
    .out_data    (vid_data),
    .out_slot    (),
    .out_line    (),
    .frame_start (frame_start)
  );

  // ------------------------------
  // lock flag
  // ------------------------------

  // set on the first frame start, held until reset
  always_ff @(posedge vid_clk or negedge arst_n) begin
    if (!arst_n) begin
      locked_q <= 1'b0;
    end else if (frame_start) begin
      locked_q <= 1'b1;
    end
  end

  // high together with sav0 of line 1
  assign vid_locked = locked_q | frame_start;

endmodule

// File: sdi_ln_crc_insert.sv
// line-number and crc-18 inserter
// one crc register per stream, lsb first
// frame start pulse on sav of line 1
`timescale 1ns/1ns

module sdi_ln_crc_insert (
  input  logic                     vid_clk,
  input  logic                     arst_n,
  input  logic                     in_valid,
  input  logic [19:0]              in_data,
  input  sdi_word_pkg::word_slot_t in_slot,
  input  logic [10:0]              in_line,
  output logic                     out_valid,
  output logic [19:0]              out_data,
  output sdi_word_pkg::word_slot_t out_slot,
  output logic [10:0]              out_line,
  output logic                     frame_start
);

  import sdi_word_pkg::*;

  // x^18 + x^5 + x^4 + 1, bit-reversed for a right shift
  localparam logic [17:0] crc_poly_rev = 18'h23000;

  logic [17:0] crc_y;
  logic [17:0] crc_c;
  logic [9:0]  ln0_word;
  logic [9:0]  ln1_word;
  logic [9:0]  y_word;
  logic [9:0]  c_word;

  // one 10-bit word into the crc, lsb first
  function automatic logic [17:0] crc18_step(input logic [17:0] c, input logic [9:0] d);
    logic [17:0] r;
    logic        fb;
    r = c;
    for (int i = 0; i < 10; i++) begin
      fb = r[0] ^ d[i];
      r  = r >> 1;
      if (fb) begin
        r = r ^ crc_poly_rev;
      end
    end
    return r;
  endfunction

  // ------------------------------
  // word insertion
  // ------------------------------

  // ln0: line[6:0] in b8..b2, b9 = ~b8
  assign ln0_word = {~in_line[6], in_line[6:0], 2'b00};
  // ln1: line[10:7] in b5..b2, b9 set
  assign ln1_word = {1'b1, 3'b000, in_line[10:7], 2'b00};

  always_comb begin
    y_word = in_data[19:10];
    c_word = in_data[9:0];
    case (in_slot)
      ln0: begin
        y_word = ln0_word;
        c_word = ln0_word;
      end
      ln1: begin
        y_word = ln1_word;
        c_word = ln1_word;
      end
      // crc bits 8..0
      crc0: begin
        y_word = {~crc_y[8], crc_y[8:0]};
        c_word = {~crc_c[8], crc_c[8:0]};
      end
      // crc bits 17..9
      crc1: begin
        y_word = {~crc_y[17], crc_y[17:9]};
        c_word = {~crc_c[17], crc_c[17:9]};
      end
      default: begin
      end
    endcase
  end

  // ------------------------------
  // crc accumulation
  // ------------------------------

  // cleared just ahead of the first active word
  // runs over active, eav and ln of the next line
  always_ff @(posedge vid_clk or negedge arst_n) begin
    if (!arst_n) begin
      crc_y <= '0;
      crc_c <= '0;
    end else if (in_valid) begin
      case (in_slot)
        sav3: begin
          crc_y <= '0;
          crc_c <= '0;
        end
        active, vblank_active, eav0, eav1, eav2, eav3, ln0, ln1: begin
          crc_y <= crc18_step(crc_y, y_word);
          crc_c <= crc18_step(crc_c, c_word);
        end
        default: begin
        end
      endcase
    end
  end

  // ------------------------------
  // output registers
  // ------------------------------

  always_ff @(posedge vid_clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid   <= 1'b0;
      frame_start <= 1'b0;
    end else begin
      out_valid   <= in_valid;
      frame_start <= in_valid && (in_slot == sav0) && (in_line == 11'd1);
    end
  end

  always_ff @(posedge vid_clk) begin
    out_data <= {y_word, c_word};
    out_slot <= in_slot;
    out_line <= in_line;
  end

endmodule

// File: sdi_payload_id_insert.sv
// smpte 352m payload-id inserter
// packet word index on the payload line's hblank
// y-stream overwrite with running checksum
`timescale 1ns/1ns
`include "sdi_settings.svh"

module sdi_payload_id_insert (
  input  logic                      vid_clk,
  input  logic                      arst_n,
  input  video_std_pkg::video_std_t frame_std,
  input  logic                      frame_anc_en,
  input  logic                      in_valid,
  input  logic [19:0]               in_data,
  input  sdi_word_pkg::word_slot_t  in_slot,
  input  logic [10:0]               in_line,
  output logic                      out_valid,
  output logic [19:0]               out_data,
  output sdi_word_pkg::word_slot_t  out_slot,
  output logic [10:0]               out_line
);

  import video_std_pkg::*;
  import sdi_word_pkg::*;

  localparam logic [10:0] pid_line = 11'(`SDI_PID_LINE);

  // adf x3, did, sdid, dc, udw x4, checksum
  localparam logic [3:0] pkt_len = 4'd11;

  logic [3:0]  idx;
  logic [8:0]  csum;
  logic [31:0] pid;
  logic        on_pkt;
  logic [9:0]  pkt_word;
  logic [9:0]  y_word;

  assign pid = payload_id_bytes(frame_std);

  // inside the packet window of the payload line
  assign on_pkt = (in_slot == hblank) && (in_line == pid_line) && (idx != pkt_len);

  // ------------------------------
  // packet word select
  // ------------------------------

  always_comb begin
    case (idx)
      4'd0:       pkt_word = trs_zeros;
      4'd1, 4'd2: pkt_word = trs_ones;
      4'd3:       pkt_word = anc_word(anc_did);
      4'd4:       pkt_word = anc_word(anc_sdid);
      4'd5:       pkt_word = anc_word(anc_dc);
      4'd6:       pkt_word = anc_word(pid[31:24]);
      4'd7:       pkt_word = anc_word(pid[23:16]);
      4'd8:       pkt_word = anc_word(pid[15:8]);
      4'd9:       pkt_word = anc_word(pid[7:0]);
      // checksum, b9 = ~b8
      default:    pkt_word = {~csum[8], csum};
    endcase
  end

  // c stream always passes through
  assign y_word = (frame_anc_en && on_pkt) ? pkt_word : in_data[19:10];

  // ------------------------------
  // index and checksum
  // ------------------------------

  always_ff @(posedge vid_clk or negedge arst_n) begin
    if (!arst_n) begin
      idx  <= '0;
      csum <= '0;
    end else if (in_valid) begin
      if (in_slot != hblank) begin
        idx  <= '0;
        csum <= '0;
      end else if (on_pkt) begin
        idx <= idx + 4'd1;
        // sum covers did through last udw, 9 bits
        if ((idx >= 4'd3) && (idx <= 4'd9)) begin
          csum <= csum + pkt_word[8:0];
        end
      end
    end
  end

  // ------------------------------
  // output registers
  // ------------------------------

  always_ff @(posedge vid_clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge vid_clk) begin
    out_data <= {y_word, in_data[9:0]};
    out_slot <= in_slot;
    out_line <= in_line;
  end

endmodule

// File: sdi_timing_gen.sv
// raster timing generator
// word/line counters, trs words with protection bits
// blanking levels and color bars, slot and line tags
// per-frame latch of standard and anc enable
`timescale 1ns/1ns
`include "sdi_settings.svh"

module sdi_timing_gen (
  input  logic                     vid_clk,
  input  logic                     arst_n,
  input  video_std_pkg::video_std_t vid_std,
  input  logic                     enable_anc,
  output logic                     out_valid,
  output logic [19:0]              out_data,
  output sdi_word_pkg::word_slot_t out_slot,
  output logic [10:0]              out_line,
  output video_std_pkg::video_std_t frame_std,
  output logic                     frame_anc_en
);

  import video_std_pkg::*;
  import sdi_word_pkg::*;

  localparam int words_per_line = `SDI_ACTIVE_WORDS + `SDI_HBLANK_WORDS;
  localparam int wcnt_w = $clog2(words_per_line);
  localparam int act_w = $clog2(`SDI_ACTIVE_WORDS);

  localparam logic [wcnt_w-1:0] last_word = wcnt_w'(words_per_line - 1);
  localparam logic [wcnt_w-1:0] sav_start = wcnt_w'(`SDI_HBLANK_WORDS - 4);
  localparam logic [wcnt_w-1:0] act_start = wcnt_w'(`SDI_HBLANK_WORDS);
  localparam logic [10:0] total_lines = 11'(`SDI_TOTAL_LINES);
  localparam logic [10:0] first_active = 11'(`SDI_FIRST_ACTIVE);
  localparam logic [10:0] last_active = 11'(`SDI_LAST_ACTIVE);

  // progressive only
  localparam logic f_bit = 1'b0;

  logic              run;
  logic [wcnt_w-1:0] word_cnt;
  logic [10:0]       line_cnt;
  logic              act_line;
  logic              v_bit;
  logic              h_bit;
  logic [9:0]        xyz;
  logic [wcnt_w-1:0] sav_pos;
  logic [wcnt_w-1:0] act_pos;
  logic [2:0]        bar_sel;
  word_slot_t        slot;
  logic [19:0]       word;

  // ------------------------------
  // counters
  // ------------------------------

  // one idle cycle after reset, then free-running
  always_ff @(posedge vid_clk or negedge arst_n) begin
    if (!arst_n) begin
      run      <= 1'b0;
      word_cnt <= '0;
      line_cnt <= 11'd1;
    end else begin
      run <= 1'b1;
      if (run) begin
        if (word_cnt == last_word) begin
          word_cnt <= '0;
          // wrap back to line 1
          if (line_cnt == total_lines) begin
            line_cnt <= 11'd1;
          end else begin
            line_cnt <= line_cnt + 11'd1;
          end
        end else begin
          word_cnt <= word_cnt + 1'b1;
        end
      end
    end
  end

  // ------------------------------
  // slot decode
  // ------------------------------

  assign act_line = (line_cnt >= first_active) && (line_cnt <= last_active);
  assign sav_pos  = word_cnt - sav_start;
  assign act_pos  = word_cnt - act_start;
  // upper three bits of the active index pick the bar
  assign bar_sel  = act_pos[act_w-1 -: 3];

  always_comb begin
    if (word_cnt >= act_start) begin
      slot = act_line ? active : vblank_active;
    end else if (word_cnt >= sav_start) begin
      case (sav_pos[1:0])
        2'd0:    slot = sav0;
        2'd1:    slot = sav1;
        2'd2:    slot = sav2;
        default: slot = sav3;
      endcase
    end else begin
      case (word_cnt)
        wcnt_w'(0): slot = eav0;
        wcnt_w'(1): slot = eav1;
        wcnt_w'(2): slot = eav2;
        wcnt_w'(3): slot = eav3;
        wcnt_w'(4): slot = ln0;
        wcnt_w'(5): slot = ln1;
        wcnt_w'(6): slot = crc0;
        wcnt_w'(7): slot = crc1;
        default:    slot = hblank;
      endcase
    end
  end

  // ------------------------------
  // word build
  // ------------------------------

  // v set outside active picture, h set for eav
  assign v_bit = ~act_line;
  assign h_bit = (slot == eav3);

  // 1 f v h p3 p2 p1 p0 0 0
  assign xyz = {1'b1, f_bit, v_bit, h_bit,
                v_bit ^ h_bit, f_bit ^ h_bit, f_bit ^ v_bit, f_bit ^ v_bit ^ h_bit,
                2'b00};

  always_comb begin
    case (slot)
      eav0, sav0:             word = {trs_ones, trs_ones};
      eav1, eav2, sav1, sav2: word = {trs_zeros, trs_zeros};
      eav3, sav3:             word = {xyz, xyz};
      active:                 word = {bar_y[bar_sel], bar_c[bar_sel]};
      // ln/crc slots are filled in downstream
      default:                word = {y_blank, c_blank};
    endcase
  end

  // ------------------------------
  // output registers
  // ------------------------------

  always_ff @(posedge vid_clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= run;
    end
  end

  always_ff @(posedge vid_clk) begin
    out_data <= word;
    out_slot <= slot;
    out_line <= line_cnt;
  end

  // standard and anc enable held for the whole frame
  always_ff @(posedge vid_clk or negedge arst_n) begin
    if (!arst_n) begin
      frame_std    <= std_sd;
      frame_anc_en <= 1'b0;
    end else if (run && (word_cnt == '0) && (line_cnt == 11'd1)) begin
      frame_std    <= vid_std;
      frame_anc_en <= enable_anc;
    end
  end

endmodule

// File: sdi_word_pkg.sv
// trs and anc word constants, blanking levels
// word slot tags, 75% color-bar table
// anc parity helper
package sdi_word_pkg;

  // position tag carried beside each word
  typedef enum logic [3:0] {
    eav0, eav1, eav2, eav3,
    ln0, ln1,
    crc0, crc1,
    hblank,
    sav0, sav1, sav2, sav3,
    active,
    vblank_active
  } word_slot_t;

  // ------------------------------
  // trs / anc constants
  // ------------------------------

  // preamble is ones, zeros, zeros
  localparam logic [9:0] trs_ones  = 10'h3ff;
  localparam logic [9:0] trs_zeros = 10'h000;

  // packet header and fixed fields
  localparam logic [7:0] anc_did  = 8'h41;
  localparam logic [7:0] anc_sdid = 8'h01;
  localparam logic [7:0] anc_dc   = 8'h04;

  // blanking levels
  localparam logic [9:0] y_blank = 10'h040;
  localparam logic [9:0] c_blank = 10'h200;

  // 75% bars, white to black
  localparam logic [9:0] bar_y [8] = '{
    10'h2d1, 10'h286, 10'h20d, 10'h1c2, 10'h14f, 10'h104, 10'h08b, 10'h040
  };
  localparam logic [9:0] bar_c [8] = '{
    10'h200, 10'h0b0, 10'h25e, 10'h10e, 10'h2f2, 10'h1a2, 10'h350, 10'h200
  };

  // 8-bit value to anc word
  // b8 even parity over b7..b0, b9 = ~b8
  function automatic logic [9:0] anc_word(input logic [7:0] b);
    logic p;
    p = ^b;
    return {~p, p, b};
  endfunction

endpackage

// File: video_std_pkg.sv
// video standard codes
// smpte 352m payload-id bytes per standard
package video_std_pkg;

  // 2-bit standard codes as seen on vid_std
  typedef enum logic [1:0] {
    std_sd  = 2'b00,
    std_hd  = 2'b01,
    std_3gb = 2'b10,
    std_3ga = 2'b11
  } video_std_t;

  // ------------------------------
  // payload-id lookup
  // ------------------------------

  // returns {byte1, byte2, byte3, byte4}
  // byte1 goes out first as udw0
  function automatic logic [31:0] payload_id_bytes(input video_std_t std);
    logic [31:0] bytes;
    case (std)
      // 483/576i sd
      std_sd:  bytes = {8'h81, 8'h06, 8'h00, 8'h00};
      // 720p/1080 hd
      std_hd:  bytes = {8'h85, 8'h06, 8'h80, 8'h00};
      // 3g level a
      std_3ga: bytes = {8'h89, 8'hcb, 8'h80, 8'h00};
      // 3g level b, dual link mapping
      std_3gb: bytes = {8'h8a, 8'h06, 8'h81, 8'h00};
      default: bytes = {8'h81, 8'h06, 8'h00, 8'h00};
    endcase
    return bytes;
  endfunction

endpackage

// File: sdi_settings.svh
// test raster size and blanking layout
// payload-id line selection
`ifndef SDI_SETTINGS_SVH
`define SDI_SETTINGS_SVH

// ------------------------------
// horizontal layout
// ------------------------------

// active words per line, multiple of 8 so the bars split evenly
`define SDI_ACTIVE_WORDS 64

// eav through sav inclusive
// must hold eav, ln, crc, the 11-word anc packet and sav
`define SDI_HBLANK_WORDS 32

// ------------------------------
// vertical layout
// ------------------------------

// lines per frame, counted from 1
`define SDI_TOTAL_LINES 12

// active picture lines
`define SDI_FIRST_ACTIVE 3
`define SDI_LAST_ACTIVE 10

// line carrying the 352m packet
`define SDI_PID_LINE 2

`endif
